// File: logic/sampler_pkg.sv
// ------------------------------------------------
// Shared sizes, thresholds and types of the sampler.
// Voltages are fixed-point millivolts, shifted left
// by fp_offset to give channel codes.
// Only one stored sample; its length is n_samples.
// ------------------------------------------------
package sampler_pkg;

    // Width of one audio word on every channel.
    localparam int sample_w = 16;

    // Millivolts to channel codes, by left shift.
    localparam int fp_offset = 2;

    // Trigger thresholds in millivolts.
    localparam int mv_hi = 1000;
    localparam int mv_lo = 400;

    // Same thresholds as channel codes (4000 and 1600).
    localparam int trigger_hi = mv_hi <<< fp_offset;
    localparam int trigger_lo = mv_lo <<< fp_offset;

    // Number of words in the stored sample.
    localparam int n_samples = 48;

    // Position must reach n_samples itself as the end marker.
    localparam int addr_w = $clog2(n_samples + 1);

    // Clock cycles each stored word is held.
    localparam int rate_div = 2;

    // Divider width is at least one bit.
    localparam int div_w = (rate_div > 1) ? $clog2(rate_div) : 1;

    // Hex file with one signed word per line.
    localparam string rom_path = "logic/clap_samples.hex";

    // One frame of the four audio channels.
    // ch0 sits in the top 16 bits.
    typedef struct packed {
        logic signed [sample_w-1:0] ch0;
        logic signed [sample_w-1:0] ch1;
        logic signed [sample_w-1:0] ch2;
        logic signed [sample_w-1:0] ch3;
    } audio_frame_t;

endpackage

// File: logic/trigger_detect.sv
// ------------------------------------------------
// Hysteresis comparator on the trigger channel.
// Arms at trigger_hi and re-arms below trigger_lo.
// Level is a signed code; negative input is low.
// ------------------------------------------------
`timescale 1ns/1ns

module trigger_detect (
    input  logic                                sample_clk,
    input  logic                                rst,
    input  logic signed [sampler_pkg::sample_w-1:0] level,
    output logic                                gate
);

    import sampler_pkg::*;

    // Threshold compare results.
    logic above_hi;
    logic below_lo;

    // Signed compare, so negative levels count as low.
    assign above_hi = (level >= trigger_hi);
    assign below_lo = (level < trigger_lo);

    always_ff @(posedge sample_clk) begin
        if (rst) begin
            gate <= 1'b0;
        end else if (!gate && above_hi) begin
            // Rising crossing arms the gate.
            gate <= 1'b1;
        end else if (gate && below_lo) begin
            // Only a clear drop re-arms.
            gate <= 1'b0;
        end
        // Between the thresholds gate holds its value.
    end

endmodule

// File: logic/playback_ctrl.sv
// ------------------------------------------------
// Read position and rate divider of the player.
// Position is held at zero while gate is low.
// Position saturates at n_samples, the end marker;
// a new run needs gate to drop and rise again.
// ------------------------------------------------
`timescale 1ns/1ns

module playback_ctrl (
    input  logic                            sample_clk,
    input  logic                            rst,
    input  logic                            gate,
    output logic [sampler_pkg::addr_w-1:0]  pos,
    output logic                            active
);

    import sampler_pkg::*;

    // Rate divider counting modulo rate_div.
    logic [div_w-1:0] div;

    // Divider is on its last count.
    logic div_wrap;

    // Position has reached the end marker.
    logic at_end;

    assign div_wrap = (div == div_w'(rate_div - 1));
    assign at_end   = (pos == addr_w'(n_samples));

    always_ff @(posedge sample_clk) begin
        if (rst || !gate) begin
            // Gate low holds the first word and restarts the divider.
            div <= '0;
            pos <= '0;
        end else begin
            if (div_wrap) begin
                div <= '0;
            end else begin
                div <= div + 1'b1;
            end
            // Advance once per rate_div cycles.
            if (div_wrap && !at_end) begin
                pos <= pos + 1'b1;
            end
        end
    end

    // High while pos addresses a stored word.
    // Falls once per trigger, when pos reaches the end.
    assign active = (pos < addr_w'(n_samples));

endmodule

// File: logic/sample_rom.sv
// ------------------------------------------------
// Sample ROM with a registered read port.
// Contents load from rom_path at elaboration.
// Reads at or past n_samples are undefined.
// ------------------------------------------------
`timescale 1ns/1ns

module sample_rom (
    input  logic                                    sample_clk,
    input  logic        [sampler_pkg::addr_w-1:0]   pos,
    output logic signed [sampler_pkg::sample_w-1:0] word
);

    import sampler_pkg::*;

    // Stored sample, one word per position.
    logic signed [sample_w-1:0] mem [n_samples];

    initial begin
        $readmemh(rom_path, mem);
    end

    // One cycle of read latency.
    always_ff @(posedge sample_clk) begin
        word <= mem[pos];
    end

endmodule

// File: logic/output_stage.sv
// ------------------------------------------------
// Registered output frame.
// ch0 carries the ROM word or silence; ch1..ch3
// are copied, all with one cycle of latency.
// active arrives one cycle ahead of the ROM word.
// ------------------------------------------------
`timescale 1ns/1ns

module output_stage (
    input  logic                                    sample_clk,
    input  logic                                    rst,
    input  logic signed [sampler_pkg::sample_w-1:0] word,
    input  logic                                    active,
    input  logic                                    gate,
    input  sampler_pkg::audio_frame_t               audio_in,
    output sampler_pkg::audio_frame_t               audio_out,
    output logic                                    playing
);

    // active delayed to line up with the ROM word.
    logic active_d;

    always_ff @(posedge sample_clk) begin
        if (rst) begin
            active_d  <= 1'b0;
            audio_out <= '0;
            playing   <= 1'b0;
        end else begin
            active_d <= active;
            // Past the end of the sample, hold 0 V.
            audio_out.ch0 <= active_d ? word : '0;
            audio_out.ch1 <= audio_in.ch1;
            audio_out.ch2 <= audio_in.ch2;
            audio_out.ch3 <= audio_in.ch3;
            // Registered with ch0 so the two stay aligned.
            playing <= active_d && gate;
        end
    end

endmodule

// File: logic/sampler_top.sv
// ------------------------------------------------
// One-shot sample player, four channels.
// Trigger on input ch0, sample out on output ch0;
// ch1..ch3 pass through one cycle late.
// Single clock domain, no handshake.
// ------------------------------------------------
`timescale 1ns/1ns

module sampler_top (
    input  logic                        sample_clk,
    input  logic                        rst,
    input  sampler_pkg::audio_frame_t   audio_in,
    output sampler_pkg::audio_frame_t   audio_out,
    output logic                        playing
);

    import sampler_pkg::*;

    // Trigger level after hysteresis.
    logic gate;

    // Read position and its in-range flag.
    logic [addr_w-1:0] pos;
    logic              active;

    // ROM output, one cycle behind pos.
    logic signed [sample_w-1:0] word;

    trigger_detect u_trigger_detect (
        .sample_clk (sample_clk),
        .rst        (rst),
        .level      (audio_in.ch0),
        .gate       (gate)
    );

    playback_ctrl u_playback_ctrl (
        .sample_clk (sample_clk),
        .rst        (rst),
        .gate       (gate),
        .pos        (pos),
        .active     (active)
    );

    sample_rom u_sample_rom (
        .sample_clk (sample_clk),
        .pos        (pos),
        .word       (word)
    );

    // Output stage masks words read past the end.
    output_stage u_output_stage (
        .sample_clk (sample_clk),
        .rst        (rst),
        .word       (word),
        .active     (active),
        .gate       (gate),
        .audio_in   (audio_in),
        .audio_out  (audio_out),
        .playing    (playing)
    );

endmodule

// File: verif/sampler_checker.sv
// --------------------------------------------------
// Output checker for the sample player.
// Models gate, read position and output pipeline
// from the timing rules and compares on every
// falling edge once a reset cycle has been seen.
// seg_end marks the last cycle of a segment.
// --------------------------------------------------
`timescale 1ns/1ns

module sampler_checker (
    input  logic                      sample_clk,
    input  logic                      rst,
    input  sampler_pkg::audio_frame_t audio_in,
    input  sampler_pkg::audio_frame_t audio_out,
    input  logic                      playing,
    input  logic                      seg_end,
    input  logic                      seg_gate,
    output int                        value_errors,
    output int                        seg_errors
);

    import sampler_pkg::*;

    // Gate-high cycles after which the position sits at the end.
    localparam int run_max = n_samples * rate_div;

    logic signed [sample_w-1:0] rom_ref [n_samples];

    // Model state after the latest rising edge.
    logic                       gate_m;
    int                         run_m;
    logic                       in_range_d;
    logic signed [sample_w-1:0] word_m;
    audio_frame_t               exp_out;
    logic                       exp_playing;
    logic                       armed;
    int                         seg_count;

    task automatic report_mismatch(input string name, input logic [sample_w-1:0] exp_v,
                                   input logic [sample_w-1:0] act_v);
        value_errors++;
        $display("mismatch %s expected 0x%h actual 0x%h at %0t ns", name, exp_v, act_v, $time);
    endtask

    task automatic compare_outputs();
        if (audio_out.ch0 !== exp_out.ch0) begin
            report_mismatch("audio_out.ch0", exp_out.ch0, audio_out.ch0);
        end
        if (audio_out.ch1 !== exp_out.ch1) begin
            report_mismatch("audio_out.ch1", exp_out.ch1, audio_out.ch1);
        end
        if (audio_out.ch2 !== exp_out.ch2) begin
            report_mismatch("audio_out.ch2", exp_out.ch2, audio_out.ch2);
        end
        if (audio_out.ch3 !== exp_out.ch3) begin
            report_mismatch("audio_out.ch3", exp_out.ch3, audio_out.ch3);
        end
        if (playing !== exp_playing) begin
            report_mismatch("playing", sample_w'(exp_playing), sample_w'(playing));
        end
    endtask

    // Advance the model by one rising edge using the inputs now applied.
    task automatic step_model();
        logic [addr_w-1:0] pos_now;
        int                lvl;
        pos_now = addr_w'(run_m / rate_div);
        lvl     = int'(audio_in.ch0);
        if (rst) begin
            gate_m      = 1'b0;
            run_m       = 0;
            in_range_d  = 1'b0;
            word_m      = rom_ref[0];
            exp_out     = '0;
            exp_playing = 1'b0;
            armed       = 1'b1;
        end else begin
            // Output register sees last cycle's ROM word and range flag.
            exp_out.ch0 = in_range_d ? word_m : '0;
            exp_out.ch1 = audio_in.ch1;
            exp_out.ch2 = audio_in.ch2;
            exp_out.ch3 = audio_in.ch3;
            exp_playing = in_range_d && gate_m;
            in_range_d  = (pos_now < addr_w'(n_samples));
            if (in_range_d) begin
                word_m = rom_ref[pos_now];
            end
            // Time since the gate rose is held at the end of the sample.
            if (!gate_m) begin
                run_m = 0;
            end else if (run_m < run_max) begin
                run_m++;
            end
            // Hysteresis between the two thresholds.
            if (!gate_m && lvl >= trigger_hi) begin
                gate_m = 1'b1;
            end else if (gate_m && lvl < trigger_lo) begin
                gate_m = 1'b0;
            end
        end
    endtask

    task automatic check_segment();
        if (gate_m !== seg_gate) begin
            seg_errors++;
            $display("segment %0d ends with gate %0b but the pattern file expects %0b",
                     seg_count, gate_m, seg_gate);
        end
        seg_count++;
    endtask

    initial begin
        $readmemh(rom_path, rom_ref);
        value_errors = 0;
        seg_errors   = 0;
        seg_count    = 0;
        armed        = 1'b0;
        gate_m       = 1'b0;
        run_m        = 0;
        in_range_d   = 1'b0;
        word_m       = '0;
        exp_out      = '0;
        exp_playing  = 1'b0;
        forever begin
            @(negedge sample_clk);
            if (armed) begin
                compare_outputs();
            end
            step_model();
            // Gate after the segment's last input.
            if (seg_end) begin
                check_segment();
            end
        end
    end

endmodule

// File: verif/tb_sampler.sv
// --------------------------------------------------
// Testbench top for the sample player.
// Rows of verif/sampler_word_patterns.hex hold six
// 16-bit words; n_segs must equal the row count.
// Inputs change 1 ns after the rising edge.
// --------------------------------------------------
`timescale 1ns/1ns

module tb_sampler;

    import sampler_pkg::*;

    // Pattern file layout.
    localparam int    n_segs       = 25;
    localparam int    seg_fields   = 6;
    localparam string pattern_path = "verif/sampler_word_patterns.hex";

    // Run length beyond the pattern holds.
    localparam int reset_cycles = 10;
    localparam int drain_cycles = 8;
    localparam int margin       = 100;

    logic         sample_clk;
    logic         rst;
    audio_frame_t audio_in;
    audio_frame_t audio_out;
    logic         playing;

    // Segment boundary and its expected gate, for the checker.
    logic seg_end;
    logic seg_gate;

    int value_errors;
    int seg_errors;
    int file_errors;

    logic [15:0] pattern [n_segs * seg_fields];

    int cycle_count = 0;
    int cycle_limit = 0;

    sampler_top DUT (
        .sample_clk (sample_clk),
        .rst        (rst),
        .audio_in   (audio_in),
        .audio_out  (audio_out),
        .playing    (playing)
    );

    sampler_checker u_checker (
        .sample_clk   (sample_clk),
        .rst          (rst),
        .audio_in     (audio_in),
        .audio_out    (audio_out),
        .playing      (playing),
        .seg_end      (seg_end),
        .seg_gate     (seg_gate),
        .value_errors (value_errors),
        .seg_errors   (seg_errors)
    );

    initial begin
        sample_clk = 1'b0;
        forever begin
            #4 sample_clk = ~sample_clk;
        end
    end

    always @(posedge sample_clk) begin
        cycle_count <= cycle_count + 1;
    end

    initial begin
        wait (cycle_limit > 0);
        while (cycle_count < cycle_limit) begin
            @(posedge sample_clk);
        end
        $display("timeout: the stimulus did not finish within %0d cycles", cycle_limit);
        $display("Simulation finished: FAIL");
        $finish;
    end

    task automatic apply_segment(input int seg);
        int base;
        int hold;
        base = seg * seg_fields;
        hold = int'(pattern[base + 4]);
        for (int c = 0; c < hold; c++) begin
            audio_in.ch0 = pattern[base];
            audio_in.ch1 = pattern[base + 1];
            audio_in.ch2 = pattern[base + 2];
            audio_in.ch3 = pattern[base + 3];
            seg_gate     = pattern[base + 5][0];
            seg_end      = (c == hold - 1);
            @(posedge sample_clk);
            #1;
        end
    endtask

    initial begin
        int total_hold;
        rst         = 1'b1;
        audio_in    = '0;
        seg_end     = 1'b0;
        seg_gate    = 1'b0;
        file_errors = 0;
        total_hold  = 0;
        $readmemh(pattern_path, pattern);
        for (int s = 0; s < n_segs; s++) begin
            if ($isunknown(pattern[s * seg_fields + 4])) begin
                file_errors++;
                $display("pattern file row %0d is missing or unreadable", s);
            end else begin
                total_hold += int'(pattern[s * seg_fields + 4]);
            end
        end
        cycle_limit = reset_cycles + total_hold + drain_cycles + margin;
        repeat (reset_cycles) @(posedge sample_clk);
        #1;
        rst = 1'b0;
        for (int s = 0; s < n_segs; s++) begin
            apply_segment(s);
        end
        seg_end = 1'b0;
        // Let the last inputs pass through the pipeline.
        repeat (drain_cycles) @(posedge sample_clk);
        $display("error counts: %0d value, %0d segment, %0d pattern file",
                 value_errors, seg_errors, file_errors);
        if (value_errors == 0 && seg_errors == 0 && file_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: logic/clap_samples.hex
// One signed 16-bit sample word per line, two's complement hex.
0012
0A3C
F1E8
1B70
E2A4
2F10
D0C8
3A5C
C6F0
3124
D8B0
27E4
DE14
1F9C
E6A8
18D0
EC40
134C
F0F8
0F20
F4B4
0BC8
F7A0
0914
F9E4
06F0
FB8C
0540
FCD8
03F4
FDD0
02FC
FE8C
0238
FF1C
01A4
FF80
0130
FFC4
00D8
FFE8
0090
0004
0058
FFF4
0030
FFFC
0010

// File: verif/sampler_word_patterns.hex
// Columns: ch0 ch1 ch2 ch3 hold gate, one stimulus segment per row, 16-bit hex each.
// ch0 codes: trigger_hi is 0FA0 and trigger_lo is 0640; gate is the level after the row.
0100 1111 2222 3333 0014 0000
09C4 8001 7FFF FFFF 000F 0000
F000 ABCD 0000 8000 0005 0000
0F9F 0F0F F0F0 5A5A 0008 0000
1388 0123 4567 89AB 003C 0001
09C4 CDEF 1357 9BDF 0014 0001
0FA0 2468 ACE0 FEDC 0028 0001
1388 7FFE 8002 0001 000A 0001
0000 FFFE 0002 C000 000A 0000
1388 1234 5678 9ABC 001E 0001
063F DEF0 1357 2468 0006 0000
0640 3C3C C3C3 0F0F 0005 0000
7FFF 55AA AA55 8888 006E 0001
0640 7777 9999 BBBB 000A 0001
0200 0001 FFFF 8001 000C 0000
1388 4321 8765 CBA9 0001 0001
0A00 E000 1000 F800 0008 0001
8000 0800 F7FF 7000 000A 0000
0FA0 6666 A5A5 1F1F 0004 0001
0000 9E37 61C8 A0B1 0003 0000
1388 2B2B D4D4 0440 0014 0001
063F 8421 7BDE 0110 0001 0000
1388 3210 CDEF 9999 0064 0001
0C00 FACE 0530 8F8F 000A 0001
0100 1111 2222 3333 0014 0000

// File: project.f
logic/sampler_pkg.sv
logic/trigger_detect.sv
logic/playback_ctrl.sv
logic/sample_rom.sv
logic/output_stage.sv
logic/sampler_top.sv
verif/sampler_checker.sv
verif/tb_sampler.sv

// File: Makefile
# Verilator flow for the sampler testbench.
# The run passes only if the log holds the pass line.

TOP := tb_sampler

.PHONY: all build run lint clean

all: run

build:
	verilator --binary -Wno-fatal --top-module $(TOP) -Mdir obj_dir -f project.f

run: build
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "Simulation finished: PASS" sim.log

lint:
	verilator --lint-only --timing -Wall --top-module sampler_top -f project.f

clean:
	rm -rf obj_dir sim.log
